/* verilog/dma_sched_pkg.sv */
package dma_sched_pkg;

    //==========================================================================
    // Widths and basic types
    //==========================================================================

    localparam int ADDR_W  = 32;
    localparam int BEATS_W = 16;

    // Descriptor packet from the descriptor engine
    localparam int DESC_W  = 128;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [BEATS_W-1:0] beats_t;

    //==========================================================================
    // Descriptor layout
    //==========================================================================

    // Low bit of each multi-bit field
    localparam int DESC_SRC_LO    = 0;
    localparam int DESC_DST_LO    = 32;
    localparam int DESC_LEN_LO    = 64;
    localparam int DESC_NEXT_LO   = 80;
    // Single-bit flags
    localparam int DESC_VALID_BIT = 112;
    localparam int DESC_LAST_BIT  = 113;
    // Bits 127:114 reserved

    //==========================================================================
    // Grant timeout
    //==========================================================================

    // Consecutive ungranted request cycles before the channel faults
    localparam int TIMEOUT_CYCLES = 16;
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES + 1);

    typedef logic [TIMEOUT_W-1:0] stall_t;

    localparam stall_t STALL_LIMIT = stall_t'(TIMEOUT_CYCLES);

    // Channel states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_FETCH     = 3'd1,
        ST_READ      = 3'd2,
        ST_WRITE     = 3'd3,
        ST_COMPLETE  = 3'd4,
        ST_NEXT_DESC = 3'd5,
        ST_ERROR     = 3'd6
    } sched_state_t;

endpackage

/* verilog/sched_ctrl_if.sv */
`timescale 1ns/10ps

interface sched_ctrl_if;

    // Current channel state, owned by the FSM
    dma_sched_pkg::sched_state_t state;

    // Descriptor status from the field registers
    logic                  desc_ok;
    logic                  chain;
    dma_sched_pkg::beats_t desc_len;

    // Counters at zero, one per phase
    logic                  read_zero;
    logic                  write_zero;

    // Any error source, forces the error state
    logic                  fault;

    modport ctrl   (output state, input chain, read_zero, write_zero, fault);
    modport desc   (input state, output desc_ok, chain, desc_len);
    modport beats  (input state, desc_len, output read_zero, write_zero);
    modport faults (input state, desc_ok, output fault);

endinterface

/* verilog/sched_fsm.sv */
`timescale 1ns/10ps

module sched_fsm (
    input  logic         clk,
    input  logic         r_channel_reset_active,
    input  logic         desc_valid,
    output logic         desc_ready,
    input  logic         cfg_enable,
    sched_ctrl_if.ctrl   ctrl,
    output logic         idle,
    output logic         error_state
);

    dma_sched_pkg::sched_state_t r_state;
    dma_sched_pkg::sched_state_t w_next_state;

    //==========================================================================
    // State register
    //==========================================================================

    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_state <= dma_sched_pkg::ST_IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    //==========================================================================
    // Next state
    //==========================================================================

    always_comb begin
        // Hold by default
        w_next_state = r_state;
        if (ctrl.fault) begin
            // Any fault wins over the normal flow
            w_next_state = dma_sched_pkg::ST_ERROR;
        end else begin
            case (r_state)
                dma_sched_pkg::ST_IDLE: begin
                    // Start only when software has enabled the channel
                    if (desc_valid && cfg_enable) begin
                        w_next_state = dma_sched_pkg::ST_FETCH;
                    end
                end
                // Invalid descriptor shows up as fault, so always read
                dma_sched_pkg::ST_FETCH: w_next_state = dma_sched_pkg::ST_READ;
                dma_sched_pkg::ST_READ: begin
                    if (ctrl.read_zero) begin
                        w_next_state = dma_sched_pkg::ST_WRITE;
                    end
                end
                dma_sched_pkg::ST_WRITE: begin
                    if (ctrl.write_zero) begin
                        w_next_state = dma_sched_pkg::ST_COMPLETE;
                    end
                end
                dma_sched_pkg::ST_COMPLETE: begin
                    // Follow the chain or fall back to idle
                    w_next_state = ctrl.chain ? dma_sched_pkg::ST_NEXT_DESC
                                              : dma_sched_pkg::ST_IDLE;
                end
                dma_sched_pkg::ST_NEXT_DESC: begin
                    // Chained descriptor needs no enable
                    if (desc_valid) begin
                        w_next_state = dma_sched_pkg::ST_FETCH;
                    end
                end
                // Fault already low here
                dma_sched_pkg::ST_ERROR: w_next_state = dma_sched_pkg::ST_IDLE;
                default: w_next_state = dma_sched_pkg::ST_ERROR;
            endcase
        end
    end

    //==========================================================================
    // Outputs
    //==========================================================================

    assign ctrl.state  = r_state;

    // Descriptor port open while waiting for a descriptor
    assign desc_ready  = (r_state == dma_sched_pkg::ST_IDLE) ||
                         (r_state == dma_sched_pkg::ST_NEXT_DESC);
    assign idle        = (r_state == dma_sched_pkg::ST_IDLE);
    assign error_state = (r_state == dma_sched_pkg::ST_ERROR);

endmodule

/* verilog/desc_regs.sv */
`timescale 1ns/10ps

module desc_regs (
    input  logic                               clk,
    input  logic                               r_channel_reset_active,
    input  logic                               desc_valid,
    input  logic                               desc_ready,
    input  logic [dma_sched_pkg::DESC_W-1:0]   desc_packet,
    sched_ctrl_if.desc                         desc,
    output dma_sched_pkg::addr_t               rd_addr,
    output dma_sched_pkg::addr_t               wr_addr,
    output dma_sched_pkg::addr_t               next_desc_ptr
);

    // Latched descriptor fields
    dma_sched_pkg::addr_t  r_src;
    dma_sched_pkg::addr_t  r_dst;
    dma_sched_pkg::beats_t r_len;
    logic                  r_last;
    logic                  r_valid;

    logic                  w_accept;

    // Descriptor handshake
    assign w_accept = desc_valid && desc_ready;

    //==========================================================================
    // Field capture
    //==========================================================================

    always_ff @(posedge clk) begin
        if (w_accept) begin
            r_src         <= desc_packet[dma_sched_pkg::DESC_SRC_LO +: dma_sched_pkg::ADDR_W];
            r_dst         <= desc_packet[dma_sched_pkg::DESC_DST_LO +: dma_sched_pkg::ADDR_W];
            r_len         <= desc_packet[dma_sched_pkg::DESC_LEN_LO +: dma_sched_pkg::BEATS_W];
            next_desc_ptr <= desc_packet[dma_sched_pkg::DESC_NEXT_LO +: dma_sched_pkg::ADDR_W];
            r_last        <= desc_packet[dma_sched_pkg::DESC_LAST_BIT];
        end
        // Working addresses for the engines
        if (desc.state == dma_sched_pkg::ST_FETCH) begin
            rd_addr <= r_src;
            wr_addr <= r_dst;
        end
    end

    // Valid flag, checked in fetch
    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_valid <= 1'b0;
        end else if (w_accept) begin
            r_valid <= desc_packet[dma_sched_pkg::DESC_VALID_BIT];
        end
    end

    assign desc.desc_ok  = r_valid;
    // Chain on nonzero pointer without the last flag
    assign desc.chain    = (next_desc_ptr != '0) && !r_last;
    assign desc.desc_len = r_len;

endmodule

/* verilog/beat_tracker.sv */
`timescale 1ns/10ps

module beat_tracker (
    input  logic                   clk,
    input  logic                   r_channel_reset_active,
    sched_ctrl_if.beats            beats,
    input  logic                   rd_done,
    input  logic                   wr_done,
    input  dma_sched_pkg::beats_t  rd_beats_done,
    input  dma_sched_pkg::beats_t  wr_beats_done,
    output logic                   rd_valid,
    output logic                   wr_valid,
    output dma_sched_pkg::beats_t  rd_beats_remaining,
    output dma_sched_pkg::beats_t  wr_beats_remaining
);

    dma_sched_pkg::beats_t r_rd_cnt;
    dma_sched_pkg::beats_t r_wr_cnt;

    //==========================================================================
    // Beats-remaining counters
    //==========================================================================

    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_rd_cnt <= '0;
            r_wr_cnt <= '0;
        end else begin
            case (beats.state)
                dma_sched_pkg::ST_FETCH: begin
                    // Both phases owe the full length
                    r_rd_cnt <= beats.desc_len;
                    r_wr_cnt <= beats.desc_len;
                end
                dma_sched_pkg::ST_READ: begin
                    // Engine may report more than is left, clamp at zero
                    if (rd_done) begin
                        r_rd_cnt <= (r_rd_cnt > rd_beats_done) ? r_rd_cnt - rd_beats_done
                                                               : '0;
                    end
                end
                dma_sched_pkg::ST_WRITE: begin
                    if (wr_done) begin
                        r_wr_cnt <= (r_wr_cnt > wr_beats_done) ? r_wr_cnt - wr_beats_done
                                                               : '0;
                    end
                end
                default: begin
                    // Counters hold
                end
            endcase
        end
    end

    assign beats.read_zero  = (r_rd_cnt == '0);
    assign beats.write_zero = (r_wr_cnt == '0);

    // Requests only while its own phase still owes beats
    assign rd_valid = (beats.state == dma_sched_pkg::ST_READ) && !beats.read_zero;
    assign wr_valid = (beats.state == dma_sched_pkg::ST_WRITE) && !beats.write_zero;

    assign rd_beats_remaining = r_rd_cnt;
    assign wr_beats_remaining = r_wr_cnt;

endmodule

/* verilog/fault_tracker.sv */
`timescale 1ns/10ps

module fault_tracker (
    input  logic          clk,
    input  logic          r_channel_reset_active,
    sched_ctrl_if.faults  faults,
    input  logic          rd_valid,
    input  logic          rd_ready,
    input  logic          wr_valid,
    input  logic          wr_ready,
    input  logic          rd_error,
    input  logic          wr_error,
    input  logic          desc_error
);

    dma_sched_pkg::stall_t r_stall_cnt;
    logic                  r_rd_err;
    logic                  r_wr_err;
    logic                  w_stalled;
    logic                  w_timeout;
    logic                  w_in_error;

    // Request pending without grant
    assign w_stalled  = (rd_valid && !rd_ready) || (wr_valid && !wr_ready);
    assign w_timeout  = (r_stall_cnt >= dma_sched_pkg::STALL_LIMIT);
    assign w_in_error = (faults.state == dma_sched_pkg::ST_ERROR);

    //==========================================================================
    // Grant timeout and sticky engine errors
    //==========================================================================

    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_stall_cnt <= '0;
            r_rd_err    <= 1'b0;
            r_wr_err    <= 1'b0;
        end else begin
            // Consecutive stalls only, stop at the limit
            if (!w_stalled) begin
                r_stall_cnt <= '0;
            end else if (!w_timeout) begin
                r_stall_cnt <= r_stall_cnt + 1'b1;
            end
            // Set on error, clear in error state once the source drops
            if (rd_error) begin
                r_rd_err <= 1'b1;
            end else if (w_in_error) begin
                r_rd_err <= 1'b0;
            end
            if (wr_error) begin
                r_wr_err <= 1'b1;
            end else if (w_in_error) begin
                r_wr_err <= 1'b0;
            end
        end
    end

    // Every error source, bad descriptor only counts in fetch
    assign faults.fault = rd_error || wr_error || desc_error ||
                          r_rd_err || r_wr_err || w_timeout ||
                          ((faults.state == dma_sched_pkg::ST_FETCH) && !faults.desc_ok);

endmodule

/* verilog/dma_scheduler.sv */
`timescale 1ns/10ps

module dma_scheduler (
    input  logic                              clk,
    input  logic                              r_channel_reset_active,
    input  logic                              cfg_enable,
    // Descriptor engine
    input  logic                              desc_valid,
    output logic                              desc_ready,
    input  logic [dma_sched_pkg::DESC_W-1:0]  desc_packet,
    input  logic                              desc_error,
    output dma_sched_pkg::addr_t              next_desc_ptr,
    // Read engine
    output logic                              rd_valid,
    input  logic                              rd_ready,
    output dma_sched_pkg::addr_t              rd_addr,
    output dma_sched_pkg::beats_t             rd_beats_remaining,
    input  logic                              rd_done,
    input  dma_sched_pkg::beats_t             rd_beats_done,
    input  logic                              rd_error,
    // Write engine
    output logic                              wr_valid,
    input  logic                              wr_ready,
    output dma_sched_pkg::addr_t              wr_addr,
    output dma_sched_pkg::beats_t             wr_beats_remaining,
    input  logic                              wr_done,
    input  dma_sched_pkg::beats_t             wr_beats_done,
    input  logic                              wr_error,
    // Status
    output logic                              idle,
    output logic                              error_state
);

    // State and status between the FSM and the datapath blocks
    sched_ctrl_if ctrl_bus ();

    //==========================================================================
    // Channel FSM and datapath
    //==========================================================================

    sched_fsm u_fsm (
        .clk(clk), .r_channel_reset_active(r_channel_reset_active),
        .desc_valid(desc_valid), .desc_ready(desc_ready), .cfg_enable(cfg_enable),
        .ctrl(ctrl_bus.ctrl), .idle(idle), .error_state(error_state)
    );

    desc_regs u_desc (
        .clk(clk), .r_channel_reset_active(r_channel_reset_active),
        .desc_valid(desc_valid), .desc_ready(desc_ready), .desc_packet(desc_packet),
        .desc(ctrl_bus.desc), .rd_addr(rd_addr), .wr_addr(wr_addr),
        .next_desc_ptr(next_desc_ptr)
    );

    beat_tracker u_beats (
        .clk(clk), .r_channel_reset_active(r_channel_reset_active),
        .beats(ctrl_bus.beats), .rd_done(rd_done), .wr_done(wr_done),
        .rd_beats_done(rd_beats_done), .wr_beats_done(wr_beats_done),
        .rd_valid(rd_valid), .wr_valid(wr_valid),
        .rd_beats_remaining(rd_beats_remaining), .wr_beats_remaining(wr_beats_remaining)
    );

    // Watches the requests driven by the beat tracker
    fault_tracker u_faults (
        .clk(clk), .r_channel_reset_active(r_channel_reset_active),
        .faults(ctrl_bus.faults), .rd_valid(rd_valid), .rd_ready(rd_ready),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .rd_error(rd_error),
        .wr_error(wr_error), .desc_error(desc_error)
    );

endmodule

/* verif/sched_checker.sv */
`timescale 1ns/10ps

module sched_checker (
    input  logic                         clk,
    input  logic                         r_channel_reset_active,
    input  dma_sched_pkg::sched_state_t  state,
    input  logic                         desc_ready,
    input  logic                         rd_valid,
    input  logic                         wr_valid,
    input  dma_sched_pkg::beats_t        rd_beats_remaining
);

    //==========================================================================
    // Request and handshake rules
    //==========================================================================

    // Only one engine is asked for beats at a time
    assert property (@(posedge clk) disable iff (r_channel_reset_active)
        rd_valid |-> !wr_valid)
        else $error("rd_valid and wr_valid high together");

    // Write phase starts only after the read side is fully done
    assert property (@(posedge clk) disable iff (r_channel_reset_active)
        wr_valid |-> (rd_beats_remaining == '0))
        else $error("wr_valid high with read beats still owed");

    // Descriptor port closed outside idle and next-descriptor
    assert property (@(posedge clk) disable iff (r_channel_reset_active)
        ((state != dma_sched_pkg::ST_IDLE) && (state != dma_sched_pkg::ST_NEXT_DESC))
        |-> !desc_ready)
        else $error("desc_ready high outside idle and next-descriptor");

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic r_channel_reset_active
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial begin
        r_channel_reset_active = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        r_channel_reset_active = 1'b0;
    end

endmodule

/* verif/tb_dma_scheduler.sv */
`timescale 1ns/10ps

module tb_dma_scheduler;

    localparam int NUM_TESTS = 6;
    localparam int MAX_LEN   = 64;
    // Longest wait for any one phase of a test
    localparam int WAIT_MAX  = MAX_LEN * 40;

    logic                              clk;
    logic                              r_channel_reset_active;
    logic                              cfg_enable;
    logic                              desc_valid;
    logic                              desc_ready;
    logic [dma_sched_pkg::DESC_W-1:0]  desc_packet;
    logic                              desc_error;
    dma_sched_pkg::addr_t              next_desc_ptr;
    logic                              rd_valid;
    logic                              rd_ready = 1'b0;
    dma_sched_pkg::addr_t              rd_addr;
    dma_sched_pkg::beats_t             rd_beats_remaining;
    logic                              rd_done = 1'b0;
    dma_sched_pkg::beats_t             rd_beats_done = '0;
    logic                              rd_error;
    logic                              wr_valid;
    logic                              wr_ready = 1'b0;
    dma_sched_pkg::addr_t              wr_addr;
    dma_sched_pkg::beats_t             wr_beats_remaining;
    logic                              wr_done = 1'b0;
    dma_sched_pkg::beats_t             wr_beats_done = '0;
    logic                              wr_error;
    logic                              idle;
    logic                              error_state;

    // Reference model and bookkeeping
    integer               seed = 32'h0054_fe75;
    int                   errors = 0;
    int                   failed_tests = 0;
    int                   first_err = 0;
    int                   exp_rd = 0;
    int                   exp_wr = 0;
    int                   burst;
    dma_sched_pkg::addr_t exp_src = '0;
    dma_sched_pkg::addr_t exp_dst = '0;
    logic                 saw_rd = 1'b0;
    logic                 saw_wr = 1'b0;
    logic                 hold_rd_ready = 1'b0;

    tb_clkgen u_clkgen (.clk(clk), .r_channel_reset_active(r_channel_reset_active));

    dma_scheduler UUT (.*);

    bind dma_scheduler sched_checker u_checker (
        .clk(clk), .r_channel_reset_active(r_channel_reset_active),
        .state(ctrl_bus.state), .desc_ready(desc_ready), .rd_valid(rd_valid),
        .wr_valid(wr_valid), .rd_beats_remaining(rd_beats_remaining)
    );

    //==========================================================================
    // Helpers
    //==========================================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Packet built from the documented field layout
    function automatic logic [dma_sched_pkg::DESC_W-1:0] make_desc(
        input logic [31:0] src, input logic [31:0] dst, input int len,
        input logic [31:0] next, input logic valid, input logic last);
        logic [dma_sched_pkg::DESC_W-1:0] pkt;
        pkt = '0;
        pkt[dma_sched_pkg::DESC_SRC_LO +: 32]  = src;
        pkt[dma_sched_pkg::DESC_DST_LO +: 32]  = dst;
        pkt[dma_sched_pkg::DESC_LEN_LO +: 16]  = 16'(len);
        pkt[dma_sched_pkg::DESC_NEXT_LO +: 32] = next;
        pkt[dma_sched_pkg::DESC_VALID_BIT]     = valid;
        pkt[dma_sched_pkg::DESC_LAST_BIT]      = last;
        return pkt;
    endfunction

    // Offer a descriptor and wait for the accepting edge
    task automatic send_desc(input logic [31:0] src, input logic [31:0] dst, input int len,
                             input logic [31:0] next, input logic valid, input logic last);
        int waited;
        waited = 0;
        exp_src = src;
        exp_dst = dst;
        exp_rd = len;
        exp_wr = len;
        desc_packet = make_desc(src, dst, len, next, valid, last);
        desc_valid = 1'b1;
        // Idle needs the enable, next-descriptor does not
        while (!(desc_ready && (cfg_enable || !idle)) && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        desc_valid = 1'b0;
        if (waited >= WAIT_MAX) begin
            report_failure("descriptor was never accepted");
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!idle && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!idle) begin
            report_failure("scheduler did not return to idle");
        end
    endtask

    // Descriptor port opens again at the end of a run
    task automatic wait_desc_ready();
        int waited;
        waited = 0;
        while (!desc_ready && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!desc_ready) begin
            report_failure("descriptor port never opened again");
        end
    endtask

    task automatic wait_read_request();
        int waited;
        waited = 0;
        while (!rd_valid && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            report_failure("read request never came up");
        end
    endtask

    task automatic wait_error(input int limit);
        int waited;
        waited = 0;
        while (!error_state && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        check_value("error_state", 32'(error_state), 1);
    endtask

    task automatic start_test();
        first_err = errors;
        saw_rd = 1'b0;
        saw_wr = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == first_err) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, errors - first_err);
        end
    endtask

    // Both counters drained
    task automatic check_drained();
        check_value("rd_beats_remaining", 32'(rd_beats_remaining), exp_rd);
        check_value("wr_beats_remaining", 32'(wr_beats_remaining), exp_wr);
    endtask

    function automatic int rand_len();
        return 1 + ($random(seed) & (MAX_LEN - 1));
    endfunction

    //==========================================================================
    // Engine models
    //==========================================================================

    // Random grants, bursts of 1 to 8 beats that may overshoot
    always @(negedge clk) begin
        rd_done = 1'b0;
        wr_done = 1'b0;
        rd_ready = 1'b0;
        wr_ready = 1'b0;
        if (rd_valid) begin
            saw_rd = 1'b1;
            check_value("rd_addr", rd_addr, exp_src);
            check_value("rd_beats_remaining", 32'(rd_beats_remaining), exp_rd);
            rd_ready = !hold_rd_ready && (($random(seed) & 3) != 0);
            if (rd_ready) begin
                burst = 1 + ($random(seed) & 7);
                rd_done = 1'b1;
                rd_beats_done = dma_sched_pkg::beats_t'(burst);
                // Remaining count saturates at zero
                exp_rd = (burst >= exp_rd) ? 0 : exp_rd - burst;
            end
        end
        if (wr_valid) begin
            saw_wr = 1'b1;
            check_value("wr_addr", wr_addr, exp_dst);
            check_value("wr_beats_remaining", 32'(wr_beats_remaining), exp_wr);
            wr_ready = (($random(seed) & 3) != 0);
            if (wr_ready) begin
                burst = 1 + ($random(seed) & 7);
                wr_done = 1'b1;
                wr_beats_done = dma_sched_pkg::beats_t'(burst);
                exp_wr = (burst >= exp_wr) ? 0 : exp_wr - burst;
            end
        end
    end

    //==========================================================================
    // Tests
    //==========================================================================

    initial begin
        logic [31:0] ptr;
        cfg_enable = 1'b0;
        desc_valid = 1'b0;
        desc_packet = '0;
        desc_error = 1'b0;
        rd_error = 1'b0;
        wr_error = 1'b0;
        wait (!r_channel_reset_active);
        @(negedge clk);
        // Reset state
        check_value("idle", 32'(idle), 1);
        check_value("desc_ready", 32'(desc_ready), 1);
        check_value("error_state", 32'(error_state), 0);
        check_value("rd_valid", 32'(rd_valid), 0);
        check_value("wr_valid", 32'(wr_valid), 0);

        // Disabled channel ignores the descriptor, then a real run
        start_test();
        desc_packet = make_desc($random(seed), $random(seed), 8, 0, 1'b1, 1'b1);
        desc_valid = 1'b1;
        repeat (20) @(negedge clk);
        desc_valid = 1'b0;
        check_value("rd_valid", 32'(saw_rd), 0);
        cfg_enable = 1'b1;
        send_desc($random(seed), $random(seed), rand_len(), 0, 1'b1, 1'b1);
        wait_idle();
        check_drained();
        end_test(1, "single transfer");

        // Zero length passes straight through
        start_test();
        send_desc($random(seed), $random(seed), 0, 0, 1'b1, 1'b1);
        wait_idle();
        check_value("rd_valid", 32'(saw_rd), 0);
        check_value("wr_valid", 32'(saw_wr), 0);
        end_test(2, "zero length");

        // Chained pair, second one with the enable low
        start_test();
        ptr = $random(seed) | 32'h10;
        send_desc($random(seed), $random(seed), rand_len(), ptr, 1'b1, 1'b0);
        wait_desc_ready();
        check_value("idle", 32'(idle), 0);
        check_value("next_desc_ptr", next_desc_ptr, ptr);
        check_drained();
        cfg_enable = 1'b0;
        send_desc($random(seed), $random(seed), rand_len(), 0, 1'b1, 1'b1);
        wait_idle();
        check_drained();
        cfg_enable = 1'b1;
        end_test(3, "chaining");

        // Valid flag clear
        start_test();
        send_desc($random(seed), $random(seed), rand_len(), 0, 1'b0, 1'b1);
        wait_error(8);
        wait_idle();
        check_value("rd_valid", 32'(saw_rd), 0);
        check_value("wr_valid", 32'(saw_wr), 0);
        end_test(4, "invalid descriptor");

        // Read engine error mid-phase, then a clean run
        start_test();
        send_desc($random(seed), $random(seed), MAX_LEN, 0, 1'b1, 1'b1);
        wait_read_request();
        rd_error = 1'b1;
        @(negedge clk);
        check_value("error_state", 32'(error_state), 1);
        check_value("rd_valid", 32'(rd_valid), 0);
        rd_error = 1'b0;
        wait_idle();
        send_desc($random(seed), $random(seed), rand_len(), 0, 1'b1, 1'b1);
        wait_idle();
        check_drained();
        end_test(5, "engine error");

        // Read engine never grants
        start_test();
        hold_rd_ready = 1'b1;
        send_desc($random(seed), $random(seed), rand_len(), 0, 1'b1, 1'b1);
        wait_read_request();
        wait_error(2 * dma_sched_pkg::TIMEOUT_CYCLES);
        hold_rd_ready = 1'b0;
        wait_idle();
        end_test(6, "grant timeout");

        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from test count and longest transfer
    initial begin
        #(NUM_TESTS * MAX_LEN * 40 * 10);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* all.f */
verilog/dma_sched_pkg.sv
verilog/sched_ctrl_if.sv
verilog/sched_fsm.sv
verilog/desc_regs.sv
verilog/beat_tracker.sv
verilog/fault_tracker.sv
verilog/dma_scheduler.sv
verif/sched_checker.sv
verif/tb_clkgen.sv
verif/tb_dma_scheduler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dma_scheduler
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
